// File: include/c2a_settings.svh
`ifndef C2A_SETTINGS_SVH
`define C2A_SETTINGS_SVH

// ----------------------------------------------------------------------
// bus widths
// ----------------------------------------------------------------------
`define C2A_ADDR_W 32
`define C2A_DATA_W 32
`define C2A_STRB_W 4
`define C2A_LEN_W 8          // axi len field
`define C2A_CNT_W 5          // host beat count, 1..16
`define C2A_MAX_BEATS 16

// ----------------------------------------------------------------------
// queue geometry
// ----------------------------------------------------------------------
`define C2A_CWFIFO_PTRW 5    // command queue, 32 entries
`define C2A_DWFIFO_PTRW 5    // write-data queue
`define C2A_RDFIFO_PTRW 5    // read-return queue

// free entries left when almost-full rises
// covers the beat sitting in the capture register
`define C2A_RDFIFO_AFULL_MARGIN 2

`endif

// File: src/c2a_pkg.sv
`default_nettype none

`include "c2a_settings.svh"

package c2a_pkg;

   // sequencer states
   typedef enum logic [1:0] {
      ST_IDLE = 2'b00,
      ST_RD   = 2'b01,
      ST_WR   = 2'b10
   } c2a_state_e;

   // host address mode
   typedef enum logic [1:0] {
      AMOD_INCR  = 2'b00,
      AMOD_RSVD  = 2'b01,  // treated as incr
      AMOD_FIXED = 2'b10,
      AMOD_WRAP  = 2'b11
   } c2a_amod_e;

   // axi burst code
   typedef enum logic [1:0] {
      BURST_FIXED = 2'b00,
      BURST_INCR  = 2'b01,
      BURST_WRAP  = 2'b10
   } c2a_burst_e;

   // ----------------------------------------------------------------------
   // queue words
   // ----------------------------------------------------------------------
   typedef struct packed {
      logic                   read;
      c2a_amod_e              amod;
      logic [`C2A_CNT_W-1:0]  cnt;
      logic [`C2A_ADDR_W-1:0] addr;
   } c2a_cmd_t;

   typedef struct packed {
      logic                   last;
      logic [`C2A_STRB_W-1:0] strb;
      logic [`C2A_DATA_W-1:0] data;
   } c2a_wbeat_t;

   typedef struct packed {
      logic                   last;
      logic [`C2A_DATA_W-1:0] data;
   } c2a_rbeat_t;

endpackage

`default_nettype wire

// File: src/c2a_fifo.sv
`timescale 1ns/10ps
`default_nettype none

`include "c2a_settings.svh"

module c2a_fifo
#(
   parameter int WIDTH        = `C2A_DATA_W,
   parameter int PTRW         = `C2A_CWFIFO_PTRW,
   parameter int AFULL_MARGIN = `C2A_RDFIFO_AFULL_MARGIN
)
(
   input  logic             aclk,
   input  logic             areset_n,
   input  logic             push_i,
   input  logic             pop_i,
   input  logic [WIDTH-1:0] din_i,
   output logic [WIDTH-1:0] dout_o,
   output logic             full_o,
   output logic             afull_o,
   output logic             empty_o
);

   localparam int DEPTH = 1 << PTRW;
   localparam logic [PTRW:0] FULL_LEVEL  = (PTRW+1)'(DEPTH);
   localparam logic [PTRW:0] AFULL_LEVEL = (PTRW+1)'(DEPTH - AFULL_MARGIN);

   logic [WIDTH-1:0] mem [DEPTH];
   logic [PTRW:0]    wr_ptr;      // extra msb tells full from empty
   logic [PTRW:0]    rd_ptr;
   logic [PTRW:0]    level;

   // ----------------------------------------------------------------------
   // flags and show-ahead output
   // ----------------------------------------------------------------------
   assign level   = wr_ptr - rd_ptr;
   assign empty_o = (wr_ptr == rd_ptr);
   assign full_o  = (level == FULL_LEVEL);
   assign afull_o = (level >= AFULL_LEVEL);
   assign dout_o  = mem[rd_ptr[PTRW-1:0]];   // head entry

   // ----------------------------------------------------------------------
   // pointers
   // ----------------------------------------------------------------------
   always_ff @(posedge aclk or negedge areset_n)
   begin
      if (!areset_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end
      else
      begin
         if (push_i)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop_i)
            rd_ptr <= rd_ptr + 1'b1;
      end
   end

   // storage
   always_ff @(posedge aclk)
   begin
      if (push_i)
         mem[wr_ptr[PTRW-1:0]] <= din_i;
   end

   // host or core side broke the push/pop rule
   a_no_overflow: assert property (@(posedge aclk) disable iff (!areset_n)
      !(push_i && full_o));

   a_no_underflow: assert property (@(posedge aclk) disable iff (!areset_n)
      !(pop_i && empty_o));

endmodule

`default_nettype wire

// File: src/c2a_cmd_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

`include "c2a_settings.svh"

module c2a_cmd_sequencer
(
   input  logic                   aclk,
   input  logic                   areset_n,
   // command queue
   input  c2a_pkg::c2a_cmd_t      cmd_i,
   input  logic                   cmd_empty_i,
   output logic                   cmd_pop_o,
   // write address channel
   output logic [`C2A_ADDR_W-1:0] awaddr_o,
   output logic [`C2A_LEN_W-1:0]  awlen_o,
   output c2a_pkg::c2a_burst_e    awburst_o,
   output logic                   awvalid_o,
   input  logic                   awready_i,
   // read address channel
   output logic [`C2A_ADDR_W-1:0] araddr_o,
   output logic [`C2A_LEN_W-1:0]  arlen_o,
   output c2a_pkg::c2a_burst_e    arburst_o,
   output logic                   arvalid_o,
   input  logic                   arready_i
);

   import c2a_pkg::*;

   localparam int LEN_W = `C2A_LEN_W;

   c2a_state_e       state;
   logic             ar_fire;
   logic             aw_fire;
   logic             load_rd;
   logic             load_wr;
   logic [LEN_W-1:0] cmd_len;
   c2a_burst_e       cmd_burst;

   function automatic c2a_burst_e map_burst(input c2a_amod_e amod);
      c2a_burst_e burst;
      case (amod)
         AMOD_FIXED: burst = BURST_FIXED;
         AMOD_WRAP:  burst = BURST_WRAP;
         default:    burst = BURST_INCR;   // incr and reserved
      endcase
      return burst;
   endfunction

   assign ar_fire = arvalid_o && arready_i;
   assign aw_fire = awvalid_o && awready_i;

   // ----------------------------------------------------------------------
   // load decision, one pop per loaded command
   // ----------------------------------------------------------------------
   always_comb
   begin
      case (state)
         ST_IDLE: cmd_pop_o = !cmd_empty_i;
         ST_RD:   cmd_pop_o = !cmd_empty_i && ar_fire;
         // a read behind a write waits for idle
         ST_WR:   cmd_pop_o = !cmd_empty_i && aw_fire && !cmd_i.read;
         default: cmd_pop_o = 1'b0;
      endcase
   end

   assign load_rd   = cmd_pop_o && cmd_i.read;
   assign load_wr   = cmd_pop_o && !cmd_i.read;
   assign cmd_len   = LEN_W'(cmd_i.cnt - 1'b1);   // axi len is beats minus one
   assign cmd_burst = map_burst(cmd_i.amod);

   // ----------------------------------------------------------------------
   // state and valids
   // ----------------------------------------------------------------------
   always_ff @(posedge aclk or negedge areset_n)
   begin
      if (!areset_n)
      begin
         state     <= ST_IDLE;
         arvalid_o <= 1'b0;
         awvalid_o <= 1'b0;
         arburst_o <= BURST_INCR;
         awburst_o <= BURST_INCR;
      end
      else
      begin
         if (load_rd)
         begin
            arvalid_o <= 1'b1;
            arburst_o <= cmd_burst;
         end
         else if (ar_fire)
            arvalid_o <= 1'b0;

         if (load_wr)
         begin
            awvalid_o <= 1'b1;
            awburst_o <= cmd_burst;
         end
         else if (aw_fire)
            awvalid_o <= 1'b0;

         if (load_rd)
            state <= ST_RD;
         else if (load_wr)
            state <= ST_WR;
         else if (ar_fire || aw_fire)
            state <= ST_IDLE;   // queue empty, or write to read turnaround
      end
   end

   // address and length
   always_ff @(posedge aclk)
   begin
      if (load_rd)
      begin
         araddr_o <= cmd_i.addr;
         arlen_o  <= cmd_len;
      end
      if (load_wr)
      begin
         awaddr_o <= cmd_i.addr;
         awlen_o  <= cmd_len;
      end
   end

   a_one_channel: assert property (@(posedge aclk) disable iff (!areset_n)
      !(arvalid_o && awvalid_o));

   a_ar_hold: assert property (@(posedge aclk) disable iff (!areset_n)
      arvalid_o && !arready_i |=> arvalid_o && $stable(araddr_o));

   a_aw_hold: assert property (@(posedge aclk) disable iff (!areset_n)
      awvalid_o && !awready_i |=> awvalid_o && $stable(awaddr_o));

endmodule

`default_nettype wire

// File: src/c2a_wdata_mover.sv
`timescale 1ns/10ps
`default_nettype none

`include "c2a_settings.svh"

module c2a_wdata_mover
(
   input  logic                   aclk,
   input  logic                   areset_n,
   input  logic                   aw_fire_i,
   // write-data queue
   input  c2a_pkg::c2a_wbeat_t    wbeat_i,
   input  logic                   wd_empty_i,
   output logic                   wd_pop_o,
   // write data channel
   output logic [`C2A_DATA_W-1:0] wdata_o,
   output logic [`C2A_STRB_W-1:0] wstrb_o,
   output logic                   wlast_o,
   output logic                   wvalid_o,
   input  logic                   wready_i
);

   import c2a_pkg::*;

   logic [`C2A_CWFIFO_PTRW:0] pend_cnt;   // addresses sent, bursts not finished
   logic                      have_pend;
   logic                      w_fire;
   logic                      wlast_fire;

   assign w_fire     = wvalid_o && wready_i;
   assign wlast_fire = w_fire && wlast_o;
   assign have_pend  = (pend_cnt != '0);

   // next beat only into an empty slot or behind a non-last handshake
   assign wd_pop_o = have_pend && !wd_empty_i && (!wvalid_o || (w_fire && !wlast_o));

   // ----------------------------------------------------------------------
   // pending write addresses
   // ----------------------------------------------------------------------
   always_ff @(posedge aclk or negedge areset_n)
   begin
      if (!areset_n)
         pend_cnt <= '0;
      else if (aw_fire_i && !wlast_fire)
         pend_cnt <= pend_cnt + 1'b1;
      else if (wlast_fire && !aw_fire_i)
         pend_cnt <= pend_cnt - 1'b1;
   end

   // ----------------------------------------------------------------------
   // W channel
   // ----------------------------------------------------------------------
   always_ff @(posedge aclk or negedge areset_n)
   begin
      if (!areset_n)
      begin
         wvalid_o <= 1'b0;
         wlast_o  <= 1'b0;
      end
      else if (wd_pop_o)
      begin
         wvalid_o <= 1'b1;
         wlast_o  <= wbeat_i.last;
      end
      else if (w_fire)
      begin
         wvalid_o <= 1'b0;   // idle at least one cycle after last
         wlast_o  <= 1'b0;
      end
   end

   always_ff @(posedge aclk)
   begin
      if (wd_pop_o)
      begin
         wdata_o <= wbeat_i.data;
         wstrb_o <= wbeat_i.strb;
      end
   end

   a_no_underflow: assert property (@(posedge aclk) disable iff (!areset_n)
      !(wlast_fire && !aw_fire_i && !have_pend));

   a_w_hold: assert property (@(posedge aclk) disable iff (!areset_n)
      wvalid_o && !wready_i |=> wvalid_o && $stable(wdata_o) && $stable(wlast_o));

endmodule

`default_nettype wire

// File: src/c2a_axi_master.sv
`timescale 1ns/10ps
`default_nettype none

`include "c2a_settings.svh"

module c2a_axi_master
(
   input  logic                   aclk,
   input  logic                   areset_n,
   // host command push
   input  logic                   cmd_push_i,
   input  logic                   cmd_read_i,
   input  logic [`C2A_ADDR_W-1:0] cmd_addr_i,
   input  logic [`C2A_CNT_W-1:0]  cmd_cnt_i,
   input  logic [1:0]             cmd_amod_i,
   output logic                   cmd_full_o,
   // host write-data push
   input  logic                   wd_push_i,
   input  logic [`C2A_DATA_W-1:0] wd_data_i,
   input  logic [`C2A_STRB_W-1:0] wd_strb_i,
   input  logic                   wd_last_i,
   output logic                   wd_full_o,
   // host read-return pop
   input  logic                   rd_pop_i,
   output logic [`C2A_DATA_W-1:0] rd_data_o,
   output logic                   rd_last_o,
   output logic                   rd_empty_o,
   // axi AW
   output logic [`C2A_ADDR_W-1:0] awaddr_o,
   output logic [`C2A_LEN_W-1:0]  awlen_o,
   output logic [1:0]             awburst_o,
   output logic                   awvalid_o,
   input  logic                   awready_i,
   // axi W
   output logic [`C2A_DATA_W-1:0] wdata_o,
   output logic [`C2A_STRB_W-1:0] wstrb_o,
   output logic                   wlast_o,
   output logic                   wvalid_o,
   input  logic                   wready_i,
   // axi AR
   output logic [`C2A_ADDR_W-1:0] araddr_o,
   output logic [`C2A_LEN_W-1:0]  arlen_o,
   output logic [1:0]             arburst_o,
   output logic                   arvalid_o,
   input  logic                   arready_i,
   // axi R
   input  logic [`C2A_DATA_W-1:0] rdata_i,
   input  logic                   rlast_i,
   input  logic                   rvalid_i,
   output logic                   rready_o
);

   import c2a_pkg::*;

   c2a_cmd_t   cmd_word_in;
   c2a_cmd_t   cmd_word_out;
   logic       cmd_empty;
   logic       cmd_pop;
   c2a_wbeat_t wd_word_in;
   c2a_wbeat_t wd_word_out;
   logic       wd_empty;
   logic       wd_pop;
   c2a_rbeat_t rd_capt;       // read beat one cycle after its handshake
   c2a_rbeat_t rd_word_out;
   logic       rd_push;
   logic       rd_afull;
   logic       aw_fire;
   logic       r_fire;

   // ----------------------------------------------------------------------
   // queue words from host fields
   // ----------------------------------------------------------------------
   always_comb
   begin
      cmd_word_in.read = cmd_read_i;
      cmd_word_in.amod = c2a_amod_e'(cmd_amod_i);
      cmd_word_in.cnt  = cmd_cnt_i;
      cmd_word_in.addr = cmd_addr_i;
      wd_word_in.last  = wd_last_i;
      wd_word_in.strb  = wd_strb_i;
      wd_word_in.data  = wd_data_i;
   end

   assign rd_data_o = rd_word_out.data;
   assign rd_last_o = rd_word_out.last;
   assign rready_o  = ~rd_afull;   // stop R before the queue can overflow
   assign aw_fire   = awvalid_o && awready_i;
   assign r_fire    = rvalid_i && rready_o;

   // ----------------------------------------------------------------------
   // queues
   // ----------------------------------------------------------------------
   c2a_fifo #(.WIDTH($bits(c2a_cmd_t)), .PTRW(`C2A_CWFIFO_PTRW),
              .AFULL_MARGIN(`C2A_RDFIFO_AFULL_MARGIN)) u_cmd_fifo (
      .aclk(aclk), .areset_n(areset_n),
      .push_i(cmd_push_i), .pop_i(cmd_pop), .din_i(cmd_word_in),
      .dout_o(cmd_word_out), .full_o(cmd_full_o), .afull_o(), .empty_o(cmd_empty));

   c2a_fifo #(.WIDTH($bits(c2a_wbeat_t)), .PTRW(`C2A_DWFIFO_PTRW),
              .AFULL_MARGIN(`C2A_RDFIFO_AFULL_MARGIN)) u_wd_fifo (
      .aclk(aclk), .areset_n(areset_n),
      .push_i(wd_push_i), .pop_i(wd_pop), .din_i(wd_word_in),
      .dout_o(wd_word_out), .full_o(wd_full_o), .afull_o(), .empty_o(wd_empty));

   c2a_fifo #(.WIDTH($bits(c2a_rbeat_t)), .PTRW(`C2A_RDFIFO_PTRW),
              .AFULL_MARGIN(`C2A_RDFIFO_AFULL_MARGIN)) u_rd_fifo (
      .aclk(aclk), .areset_n(areset_n),
      .push_i(rd_push), .pop_i(rd_pop_i), .din_i(rd_capt),
      .dout_o(rd_word_out), .full_o(), .afull_o(rd_afull), .empty_o(rd_empty_o));

   // ----------------------------------------------------------------------
   // address sequencer and write-data mover
   // ----------------------------------------------------------------------
   c2a_cmd_sequencer u_seq (
      .aclk(aclk), .areset_n(areset_n),
      .cmd_i(cmd_word_out), .cmd_empty_i(cmd_empty), .cmd_pop_o(cmd_pop),
      .awaddr_o(awaddr_o), .awlen_o(awlen_o), .awburst_o(awburst_o),
      .awvalid_o(awvalid_o), .awready_i(awready_i),
      .araddr_o(araddr_o), .arlen_o(arlen_o), .arburst_o(arburst_o),
      .arvalid_o(arvalid_o), .arready_i(arready_i));

   c2a_wdata_mover u_wmover (
      .aclk(aclk), .areset_n(areset_n), .aw_fire_i(aw_fire),
      .wbeat_i(wd_word_out), .wd_empty_i(wd_empty), .wd_pop_o(wd_pop),
      .wdata_o(wdata_o), .wstrb_o(wstrb_o), .wlast_o(wlast_o),
      .wvalid_o(wvalid_o), .wready_i(wready_i));

   // read capture, push strobe follows the handshake by one cycle
   always_ff @(posedge aclk or negedge areset_n)
   begin
      if (!areset_n)
         rd_push <= 1'b0;
      else
         rd_push <= r_fire;
   end

   always_ff @(posedge aclk)
   begin
      if (r_fire)
      begin
         rd_capt.last <= rlast_i;
         rd_capt.data <= rdata_i;
      end
   end

endmodule

`default_nettype wire

// File: verification/tb_c2a_axi_master.sv
`timescale 1ns/10ps
`default_nettype none

`include "c2a_settings.svh"

module tb_c2a_axi_master;

   localparam int          MAXP       = 64;
   localparam int          WAIT_LIMIT = 2000;   // cycles per wait
   localparam logic [31:0] SEED       = 32'd74125;
   localparam int          RQ_AFULL   = (1 << `C2A_RDFIFO_PTRW) - `C2A_RDFIFO_AFULL_MARGIN;

   logic                   aclk       = 1'b0;
   logic                   areset_n   = 1'b0;
   logic                   cmd_push_i = 1'b0;
   logic                   cmd_read_i = 1'b0;
   logic [`C2A_ADDR_W-1:0] cmd_addr_i = '0;
   logic [`C2A_CNT_W-1:0]  cmd_cnt_i  = '0;
   logic [1:0]             cmd_amod_i = '0;
   logic                   wd_push_i  = 1'b0;
   logic [`C2A_DATA_W-1:0] wd_data_i  = '0;
   logic [`C2A_STRB_W-1:0] wd_strb_i  = '0;
   logic                   wd_last_i  = 1'b0;
   logic                   rd_pop_i   = 1'b0;
   logic                   awready_i  = 1'b0;
   logic                   wready_i   = 1'b0;
   logic                   arready_i  = 1'b0;
   logic [`C2A_DATA_W-1:0] rdata_i    = '0;
   logic                   rlast_i    = 1'b0;
   logic                   rvalid_i   = 1'b0;

   logic                   cmd_full_o;
   logic                   wd_full_o;
   logic [`C2A_DATA_W-1:0] rd_data_o;
   logic                   rd_last_o;
   logic                   rd_empty_o;
   logic [`C2A_ADDR_W-1:0] awaddr_o;
   logic [`C2A_LEN_W-1:0]  awlen_o;
   logic [1:0]             awburst_o;
   logic                   awvalid_o;
   logic [`C2A_DATA_W-1:0] wdata_o;
   logic [`C2A_STRB_W-1:0] wstrb_o;
   logic                   wlast_o;
   logic                   wvalid_o;
   logic [`C2A_ADDR_W-1:0] araddr_o;
   logic [`C2A_LEN_W-1:0]  arlen_o;
   logic [1:0]             arburst_o;
   logic                   arvalid_o;
   logic                   rready_o;

   // pattern table in file order
   logic        pat_rd    [MAXP];
   logic [31:0] pat_addr  [MAXP];
   int          pat_cnt   [MAXP];
   int          pat_amod  [MAXP];
   logic [31:0] pat_base  [MAXP];
   int          wr_list   [MAXP];   // pattern index of each write
   int          rd_list   [MAXP];
   int          wr_before [MAXP];   // writes ahead of each read
   int          n_pat = 0;
   int          n_wr  = 0;
   int          n_rd  = 0;

   logic [31:0] mem [256];           // word addressed slave memory
   logic [31:0] rng_slv  = SEED;
   logic [31:0] rng_host = SEED;
   int          aw_cnt   = 0;
   int          wl_cnt   = 0;         // W bursts closed by wlast
   int          ar_cnt   = 0;
   int          r_cnt    = 0;
   int          w_beat   = 0;
   int          r_beat   = 0;
   int          slv_p    = 0;
   int          rq_level = 0;         // read-return queue level seen by the DUT
   logic        r_fire_d = 1'b0;      // R handshake still in the capture stage
   int          checks   = 0;
   int          errors   = 0;

   c2a_axi_master DUT (.*);

   always #2 aclk = ~aclk;

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // word address of one beat by the axi fixed/incr/wrap rules
   function automatic logic [7:0] beat_addr(input logic [31:0] start, input int cnt,
                                            input int amod, input int beat);
      logic [31:0] mask;
      logic [31:0] a;
      mask = 32'(cnt) - 32'd1;   // wrap counts are powers of two
      case (amod)
         2:       a = start;
         3:       a = (start & ~mask) | ((start + 32'(beat)) & mask);
         default: a = start + 32'(beat);
      endcase
      return a[7:0];
   endfunction

   function automatic int exp_burst(input int amod);
      case (amod)
         2:       return 0;   // fixed
         3:       return 2;   // wrap
         default: return 1;
      endcase
   endfunction

   task automatic check_val(input string name, input logic [31:0] exp_v,
                            input logic [31:0] act_v);
      checks++;
      if (exp_v !== act_v)
      begin
         errors++;
         $display("FAILED %s expected %h actual %h", name, exp_v, act_v);
      end
   endtask

   task automatic note_timeout(input string what);
      errors++;
      $display("timeout while waiting: %s", what);
   endtask

   task automatic finish_run();
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   endtask

   // ----------------------------------------------------------------------
   // pattern file
   // ----------------------------------------------------------------------
   task automatic load_patterns();
      int          fd;
      int          n;
      string       line;
      logic [7:0]  kind;
      logic [31:0] f_addr;
      logic [31:0] f_cnt;
      logic [31:0] f_amod;
      logic [31:0] f_base;
      fd = $fopen("verification/c2a_patterns.txt", "r");
      if (fd == 0)
      begin
         errors++;
         $display("could not open the pattern file");
         return;
      end
      while ($fgets(line, fd) > 0 && n_pat < MAXP)
      begin
         n = $sscanf(line, "%s %h %d %d %h", kind, f_addr, f_cnt, f_amod, f_base);
         if (n == 5 && (kind == "W" || kind == "R"))   // comment lines fall out here
         begin
            pat_rd[n_pat]   = (kind == "R");
            pat_addr[n_pat] = f_addr;
            pat_cnt[n_pat]  = int'(f_cnt);
            pat_amod[n_pat] = int'(f_amod);
            pat_base[n_pat] = f_base;
            if (kind == "R")
            begin
               rd_list[n_rd]   = n_pat;
               wr_before[n_rd] = n_wr;
               n_rd++;
            end
            else
            begin
               wr_list[n_wr] = n_pat;
               n_wr++;
            end
            n_pat++;
         end
      end
      $fclose(fd);
      if (n_pat == 0)
      begin
         errors++;
         $display("no patterns found in the pattern file");
      end
   endtask

   // ----------------------------------------------------------------------
   // host side
   // ----------------------------------------------------------------------
   task automatic push_commands();
      int p;
      int t;
      for (p = 0; p < n_pat; p++)
      begin
         @(posedge aclk);
         t = 0;
         while (cmd_full_o && t < WAIT_LIMIT)
         begin
            @(posedge aclk);
            t++;
         end
         if (t >= WAIT_LIMIT)
         begin
            note_timeout("command queue stayed full");
            return;
         end
         cmd_push_i <= 1'b1;
         cmd_read_i <= pat_rd[p];
         cmd_addr_i <= pat_addr[p];
         cmd_cnt_i  <= 5'(pat_cnt[p]);
         cmd_amod_i <= 2'(pat_amod[p]);
         @(posedge aclk);
         cmd_push_i <= 1'b0;   // one idle cycle so full is seen in time
      end
   endtask

   task automatic push_wdata();
      int w;
      int p;
      int b;
      int t;
      for (w = 0; w < n_wr; w++)
      begin
         p = wr_list[w];
         for (b = 0; b < pat_cnt[p]; b++)
         begin
            @(posedge aclk);
            t = 0;
            while (wd_full_o && t < WAIT_LIMIT)
            begin
               @(posedge aclk);
               t++;
            end
            if (t >= WAIT_LIMIT)
            begin
               note_timeout("write-data queue stayed full");
               return;
            end
            wd_push_i <= 1'b1;
            wd_data_i <= pat_base[p] + 32'(b);
            wd_strb_i <= '1;
            wd_last_i <= (b == pat_cnt[p] - 1);
            @(posedge aclk);
            wd_push_i <= 1'b0;
         end
      end
   endtask

   task automatic pop_rdata();
      int r;
      int p;
      int b;
      int t;
      for (r = 0; r < n_rd; r++)
      begin
         p = rd_list[r];
         for (b = 0; b < pat_cnt[p]; b++)
         begin
            rng_host = xorshift32(rng_host);
            repeat (rng_host[2:0]) @(posedge aclk);   // slow host fills the return queue
            @(posedge aclk);
            t = 0;
            while (rd_empty_o && t < WAIT_LIMIT)
            begin
               @(posedge aclk);
               t++;
            end
            if (t >= WAIT_LIMIT)
            begin
               note_timeout("read-return queue stayed empty");
               return;
            end
            check_val("rd_data", pat_base[p] + 32'(b), rd_data_o);
            check_val("rd_last", 32'(b == pat_cnt[p] - 1), 32'(rd_last_o));
            rd_pop_i <= 1'b1;
            @(posedge aclk);
            rd_pop_i <= 1'b0;
         end
      end
   endtask

   // ----------------------------------------------------------------------
   // slave model
   // ----------------------------------------------------------------------
   always @(posedge aclk)
   begin
      if (areset_n)
      begin
         rng_slv = xorshift32(rng_slv);
         awready_i <= rng_slv[0] | rng_slv[1];   // high about 3 of 4 cycles
         wready_i  <= rng_slv[4] | rng_slv[5];
         arready_i <= rng_slv[8] | rng_slv[9];
         check_val("ar_aw_exclusive", 32'd0, 32'(arvalid_o & awvalid_o));

         // R stays open until only the margin is left free in the return queue
         check_val("rready", 32'(rq_level < RQ_AFULL), 32'(rready_o));
         rq_level = rq_level + int'(r_fire_d) - int'(rd_pop_i && !rd_empty_o);
         r_fire_d = rvalid_i && rready_o;

         if (awvalid_o && awready_i)
         begin
            if (aw_cnt >= n_wr)
            begin
               errors++;
               $display("AW handshake beyond the last write pattern");
            end
            else
            begin
               slv_p = wr_list[aw_cnt];
               check_val("aw_addr", pat_addr[slv_p], awaddr_o);
               check_val("aw_len", 32'(pat_cnt[slv_p] - 1), 32'(awlen_o));
               check_val("aw_burst", 32'(exp_burst(pat_amod[slv_p])), 32'(awburst_o));
               aw_cnt++;
            end
         end

         if (wvalid_o && wready_i)
         begin
            if (wl_cnt >= aw_cnt)
            begin
               errors++;
               $display("W handshake with no write address outstanding");
            end
            else
            begin
               slv_p = wr_list[wl_cnt];
               check_val("w_data", pat_base[slv_p] + 32'(w_beat), wdata_o);
               check_val("w_strb", 32'hf, 32'(wstrb_o));
               check_val("w_last", 32'(w_beat == pat_cnt[slv_p] - 1), 32'(wlast_o));
               mem[beat_addr(pat_addr[slv_p], pat_cnt[slv_p], pat_amod[slv_p], w_beat)]
                  = wdata_o;
               if (wlast_o)
               begin
                  wl_cnt++;
                  w_beat = 0;
               end
               else
                  w_beat++;
            end
         end

         if (arvalid_o && arready_i)
         begin
            if (ar_cnt >= n_rd)
            begin
               errors++;
               $display("AR handshake beyond the last read pattern");
            end
            else
            begin
               slv_p = rd_list[ar_cnt];
               check_val("ar_addr", pat_addr[slv_p], araddr_o);
               check_val("ar_len", 32'(pat_cnt[slv_p] - 1), 32'(arlen_o));
               check_val("ar_burst", 32'(exp_burst(pat_amod[slv_p])), 32'(arburst_o));
               ar_cnt++;
            end
         end

         if (rvalid_i && rready_o)
         begin
            if (rlast_i)
            begin
               r_cnt++;
               r_beat = 0;
            end
            else
               r_beat++;
         end

         // a read returns only once the writes ahead of it in the file are done
         if (r_cnt < ar_cnt && wl_cnt >= wr_before[r_cnt])
         begin
            slv_p = rd_list[r_cnt];
            rvalid_i <= 1'b1;
            rdata_i  <= mem[beat_addr(pat_addr[slv_p], pat_cnt[slv_p], pat_amod[slv_p],
                                      r_beat)];
            rlast_i  <= (r_beat == pat_cnt[slv_p] - 1);
         end
         else
         begin
            rvalid_i <= 1'b0;
            rlast_i  <= 1'b0;
         end
      end
   end

   // ----------------------------------------------------------------------
   // main sequence
   // ----------------------------------------------------------------------
   initial
   begin
      int i;
      int t;
      for (i = 0; i < 256; i++)
         mem[i] = 32'hc0de0000 | 32'(i);   // fill tracks the address
      load_patterns();
      rng_host = xorshift32(rng_host);
      repeat (5) @(posedge aclk);
      areset_n <= 1'b1;
      repeat (3)
      begin
         @(posedge aclk);
         check_val("reset_awvalid", 32'd0, 32'(awvalid_o));
         check_val("reset_arvalid", 32'd0, 32'(arvalid_o));
         check_val("reset_wvalid", 32'd0, 32'(wvalid_o));
         check_val("reset_cmd_full", 32'd0, 32'(cmd_full_o));
         check_val("reset_wd_full", 32'd0, 32'(wd_full_o));
         check_val("reset_rd_empty", 32'd1, 32'(rd_empty_o));
      end
      fork
         push_commands();
         push_wdata();
         pop_rdata();
      join
      t = 0;
      while (wl_cnt < n_wr && t < WAIT_LIMIT)
      begin
         @(posedge aclk);
         t++;
      end
      if (t >= WAIT_LIMIT)
         note_timeout("write bursts did not all finish");
      check_val("aw_count", 32'(n_wr), 32'(aw_cnt));
      check_val("w_bursts", 32'(n_wr), 32'(wl_cnt));
      check_val("ar_count", 32'(n_rd), 32'(ar_cnt));
      check_val("r_bursts", 32'(n_rd), 32'(r_cnt));
      finish_run();
   end

endmodule

`default_nettype wire

// File: all.f
+incdir+include
src/c2a_pkg.sv
src/c2a_fifo.sv
src/c2a_cmd_sequencer.sv
src/c2a_wdata_mover.sv
src/c2a_axi_master.sv
verification/tb_c2a_axi_master.sv

// File: Makefile
SIM  = obj_dir/Vtb_c2a_axi_master
SRCS = $(wildcard src/*.sv include/*.svh verification/*.sv)

.PHONY: run clean

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "Testbench passed"

$(SIM): all.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/10ps \
		-f all.f --top-module tb_c2a_axi_master

clean:
	rm -rf obj_dir

// File: verification/c2a_patterns.txt
# kind addr count amod base, with addr and base in hex
# W pushes base+i as beat i, R expects base+i on beat i
W 00000010 4 0 00001000
W 00000020 16 0 00002000
W 00000046 4 3 00003000
W 00000030 3 2 00004000
W 00000058 8 1 00005000
W 00000073 2 3 00006000
W 00000001 1 0 00007000
R 00000010 4 0 00001000
R 00000020 16 0 00002000
R 00000044 2 0 00003002
R 00000046 4 3 00003000
R 00000030 1 2 00004002
R 00000058 8 1 00005000
R 00000073 2 3 00006000
R 00000072 1 0 00006001
R 00000080 4 0 c0de0080
R 00000001 1 0 00007000
W 00000090 4 0 00008000
R 00000090 4 0 00008000
